// ==== source/refill_pkg.sv ====
`default_nettype none

package refill_pkg;

    localparam int ADDR_W = 32;
    localparam int LINE_W = 256;

    // bytes in one cache line, the low address bits below this are dropped
    localparam int LINE_BYTES = LINE_W / 8;

    // byte address of a line
    typedef logic [ADDR_W-1:0] addr_t;

    // one whole cache line, moved as a single transfer
    typedef logic [LINE_W-1:0] line_t;

    // memory-side FSM, the busy states name the port being served
    typedef enum logic [1:0] {
        ARB_IDLE   = 2'd0,
        ARB_IFETCH = 2'd1,
        ARB_DATA   = 2'd2
    } arb_state_t;

    // last port that owned the memory path
    typedef enum logic {
        OWN_IFETCH = 1'b0,
        OWN_DATA   = 1'b1
    } owner_t;

    // owner after reset, so a tie on the first grant goes to data
    localparam owner_t OWNER_RESET = OWN_IFETCH;

    // mask that clears the offset bits of a line address
    localparam addr_t LINE_ADDR_MASK = ~addr_t'(LINE_BYTES - 1);

endpackage

`default_nettype wire

// ==== source/line_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface line_req_if
    import refill_pkg::*;
();

    // request side, held by the port until done
    logic  pending;
    addr_t addr;
    logic  we;
    line_t wdata;

    // response side, done is a single-cycle pulse
    logic  done;
    line_t rdata;

    modport port_side (
        output pending,
        output addr,
        output we,
        output wdata,
        input  done,
        input  rdata
    );

    modport arb_side (
        input  pending,
        input  addr,
        input  we,
        input  wdata,
        output done,
        output rdata
    );

endinterface

`default_nettype wire

// ==== source/ifetch_refill_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifetch_refill_port
    import refill_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          i_cyc,
    input  logic          i_stb,
    input  addr_t         i_adr,
    output line_t         o_dat,
    output logic          o_ack,
    line_req_if.port_side req
);

    logic  pending_q;
    logic  ack_q;
    addr_t addr_q;
    line_t dat_q;
    logic  take;

    // new request only when nothing is held and no ack is going out
    assign take = i_cyc && i_stb && !pending_q && !ack_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pending_q <= 1'b0;
            ack_q     <= 1'b0;
        end
        else
        begin
            // cache ack follows the arbiter's done by one cycle
            ack_q <= req.done;
            if (take)
            begin
                pending_q <= 1'b1;
            end
            else if (req.done)
            begin
                pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            addr_q <= i_adr & LINE_ADDR_MASK;
        end
        if (req.done)
        begin
            dat_q <= req.rdata;
        end
    end

    assign req.pending = pending_q;
    assign req.addr    = addr_q;

    // instruction refills never write back
    assign req.we      = 1'b0;
    assign req.wdata   = '0;

    assign o_ack = ack_q;
    assign o_dat = dat_q;

endmodule

`default_nettype wire

// ==== source/data_refill_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_refill_port
    import refill_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          i_cyc,
    input  logic          i_stb,
    input  logic          i_we,
    input  addr_t         i_adr,
    input  line_t         i_dat,
    output line_t         o_dat,
    output logic          o_ack,
    line_req_if.port_side req
);

    logic  pending_q;
    logic  ack_q;
    logic  we_q;
    addr_t addr_q;
    line_t wdata_q;
    line_t dat_q;
    logic  take;

    // one request at a time, none while the ack is on the bus
    assign take = i_cyc && i_stb && !pending_q && !ack_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pending_q <= 1'b0;
            ack_q     <= 1'b0;
            we_q      <= 1'b0;
        end
        else
        begin
            ack_q <= req.done;
            if (take)
            begin
                pending_q <= 1'b1;
                we_q      <= i_we;
            end
            else if (req.done)
            begin
                pending_q <= 1'b0;
            end
        end
    end

    // address and write-back line stay put while the request is pending
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            addr_q  <= i_adr & LINE_ADDR_MASK;
            wdata_q <= i_dat;
        end
    end

    // a write-back returns an all-zero line on its ack
    always_ff @(posedge clk)
    begin
        if (req.done)
        begin
            if (we_q)
            begin
                dat_q <= '0;
            end
            else
            begin
                dat_q <= req.rdata;
            end
        end
    end

    assign req.pending = pending_q;
    assign req.addr    = addr_q;
    assign req.we      = we_q;
    assign req.wdata   = wdata_q;

    assign o_ack = ack_q;
    assign o_dat = dat_q;

endmodule

`default_nettype wire

// ==== source/refill_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module refill_arbiter
    import refill_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    line_req_if.arb_side ireq,
    line_req_if.arb_side dreq,
    output logic         o_mem_cyc,
    output logic         o_mem_stb,
    output logic         o_mem_we,
    output addr_t        o_mem_adr,
    output line_t        o_mem_dat,
    input  line_t        i_mem_dat,
    input  logic         i_mem_ack
);

    arb_state_t state;
    arb_state_t grant;
    owner_t     owner;
    logic       cyc_q;
    logic       done_q;
    line_t      rdata_q;
    addr_t      sel_addr;
    logic       sel_we;
    line_t      sel_wdata;

    // choice made from idle, data wins a tie unless it went last
    always_comb
    begin
        grant = ARB_IDLE;
        if (ireq.pending && dreq.pending)
        begin
            if (owner == OWN_DATA)
            begin
                grant = ARB_IFETCH;
            end
            else
            begin
                grant = ARB_DATA;
            end
        end
        else if (dreq.pending)
        begin
            grant = ARB_DATA;
        end
        else if (ireq.pending)
        begin
            grant = ARB_IFETCH;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state  <= ARB_IDLE;
            owner  <= OWNER_RESET;
            cyc_q  <= 1'b0;
            done_q <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (state)
                ARB_IDLE:
                begin
                    if (grant != ARB_IDLE)
                    begin
                        state <= grant;
                        cyc_q <= 1'b1;
                        if (grant == ARB_DATA)
                        begin
                            owner <= OWN_DATA;
                        end
                        else
                        begin
                            owner <= OWN_IFETCH;
                        end
                    end
                end
                ARB_IFETCH, ARB_DATA:
                begin
                    // memory cycle first, then one cycle of done
                    if (done_q)
                    begin
                        state <= ARB_IDLE;
                    end
                    else if (cyc_q && i_mem_ack)
                    begin
                        cyc_q  <= 1'b0;
                        done_q <= 1'b1;
                    end
                end
                default:
                begin
                    state <= ARB_IDLE;
                    cyc_q <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (cyc_q && i_mem_ack)
        begin
            rdata_q <= i_mem_dat;
        end
    end

    // request fields come straight from the owning port's registers
    assign sel_addr  = (state == ARB_DATA) ? dreq.addr  : ireq.addr;
    assign sel_we    = (state == ARB_DATA) ? dreq.we    : ireq.we;
    assign sel_wdata = (state == ARB_DATA) ? dreq.wdata : ireq.wdata;

    assign o_mem_cyc = cyc_q;
    assign o_mem_stb = cyc_q;
    assign o_mem_we  = cyc_q && sel_we;
    assign o_mem_adr = sel_addr;
    assign o_mem_dat = sel_wdata;

    // done goes only to the port that owns the path
    assign ireq.done  = done_q && (state == ARB_IFETCH);
    assign dreq.done  = done_q && (state == ARB_DATA);
    assign ireq.rdata = rdata_q;
    assign dreq.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== source/refill_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module refill_top
    import refill_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // instruction cache refill slave
    input  logic  i_ic_cyc,
    input  logic  i_ic_stb,
    input  addr_t i_ic_adr,
    output line_t o_ic_dat,
    output logic  o_ic_ack,

    // data cache refill and write-back slave
    input  logic  i_dc_cyc,
    input  logic  i_dc_stb,
    input  logic  i_dc_we,
    input  addr_t i_dc_adr,
    input  line_t i_dc_dat,
    output line_t o_dc_dat,
    output logic  o_dc_ack,

    // shared master to backing memory
    output logic  o_mem_cyc,
    output logic  o_mem_stb,
    output logic  o_mem_we,
    output addr_t o_mem_adr,
    output line_t o_mem_dat,
    input  line_t i_mem_dat,
    input  logic  i_mem_ack
);

    line_req_if ireq_if ();
    line_req_if dreq_if ();

    ifetch_refill_port u_ifetch (
        .clk   (clk),
        .rst   (rst),
        .i_cyc (i_ic_cyc),
        .i_stb (i_ic_stb),
        .i_adr (i_ic_adr),
        .o_dat (o_ic_dat),
        .o_ack (o_ic_ack),
        .req   (ireq_if.port_side)
    );

    data_refill_port u_data (
        .clk   (clk),
        .rst   (rst),
        .i_cyc (i_dc_cyc),
        .i_stb (i_dc_stb),
        .i_we  (i_dc_we),
        .i_adr (i_dc_adr),
        .i_dat (i_dc_dat),
        .o_dat (o_dc_dat),
        .o_ack (o_dc_ack),
        .req   (dreq_if.port_side)
    );

    refill_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .ireq      (ireq_if.arb_side),
        .dreq      (dreq_if.arb_side),
        .o_mem_cyc (o_mem_cyc),
        .o_mem_stb (o_mem_stb),
        .o_mem_we  (o_mem_we),
        .o_mem_adr (o_mem_adr),
        .o_mem_dat (o_mem_dat),
        .i_mem_dat (i_mem_dat),
        .i_mem_ack (i_mem_ack)
    );

endmodule

`default_nettype wire

// ==== tests/refill_top_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module refill_top_props
    import refill_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  i_mem_cyc,
    input logic  i_mem_stb,
    input logic  i_mem_we,
    input addr_t i_mem_adr,
    input logic  i_mem_ack,
    input logic  i_ipend,
    input logic  i_dpend,
    input logic  i_idone,
    input logic  i_ddone
);

    // strobe only inside a cycle and held there until the ack
    stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
        (i_mem_stb || $past(i_mem_stb && !i_mem_ack)) |-> (i_mem_stb && i_mem_cyc))
        else $error("memory strobe outside a cycle or dropped before ack");

    // request fields held while the memory inserts wait states
    req_stable: assert property (@(posedge clk) disable iff (rst)
        (i_mem_cyc && !i_mem_ack) |=> ($stable(i_mem_adr) && $stable(i_mem_we)))
        else $error("memory address or write flag changed before ack");

    // done goes to one link at a time and only to a link that is pending
    one_done: assert property (@(posedge clk) disable iff (rst)
        !(i_idone && i_ddone) && (!i_idone || i_ipend) && (!i_ddone || i_dpend))
        else $error("done raised on both links or on a link with nothing pending");

endmodule

bind refill_arbiter refill_top_props u_props (
    .clk       (clk),
    .rst       (rst),
    .i_mem_cyc (o_mem_cyc),
    .i_mem_stb (o_mem_stb),
    .i_mem_we  (o_mem_we),
    .i_mem_adr (o_mem_adr),
    .i_mem_ack (i_mem_ack),
    .i_ipend   (ireq.pending),
    .i_dpend   (dreq.pending),
    .i_idone   (ireq.done),
    .i_ddone   (dreq.done)
);

`default_nettype wire

// ==== tests/tb_refill_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_refill_top
    import refill_pkg::*;
();

    localparam int ACK_LIMIT  = 200;
    localparam int STREAM_LEN = 40;
    localparam int PAIR_COUNT = 12;

    logic  clk;
    logic  rst;
    logic  ic_cyc;
    logic  ic_stb;
    addr_t ic_adr;
    line_t ic_dat;
    logic  ic_ack;
    logic  dc_cyc;
    logic  dc_stb;
    logic  dc_we;
    addr_t dc_adr;
    line_t dc_wdat;
    line_t dc_rdat;
    logic  dc_ack;
    logic  mem_cyc;
    logic  mem_stb;
    logic  mem_we;
    addr_t mem_adr;
    line_t mem_wdat;
    line_t mem_rdat;
    logic  mem_ack;

    // backing memory and the lines the testbench has written so far
    line_t       mem_model [addr_t];
    line_t       shadow [addr_t];
    addr_t       mem_log [$];
    line_t       ic_expect [$];
    line_t       dc_expect [$];
    string       ic_names [$];
    string       dc_names [$];
    logic [15:0] lfsr_state = 16'd16127;

    // precomputed random stream
    addr_t ic_addrs [STREAM_LEN];
    addr_t dc_addrs [STREAM_LEN];
    logic  dc_wes [STREAM_LEN];
    line_t dc_wdats [STREAM_LEN];

    refill_top UUT (
        .clk       (clk),
        .rst       (rst),
        .i_ic_cyc  (ic_cyc),
        .i_ic_stb  (ic_stb),
        .i_ic_adr  (ic_adr),
        .o_ic_dat  (ic_dat),
        .o_ic_ack  (ic_ack),
        .i_dc_cyc  (dc_cyc),
        .i_dc_stb  (dc_stb),
        .i_dc_we   (dc_we),
        .i_dc_adr  (dc_adr),
        .i_dc_dat  (dc_wdat),
        .o_dc_dat  (dc_rdat),
        .o_dc_ack  (dc_ack),
        .o_mem_cyc (mem_cyc),
        .o_mem_stb (mem_stb),
        .o_mem_we  (mem_we),
        .o_mem_adr (mem_adr),
        .o_mem_dat (mem_wdat),
        .i_mem_dat (mem_rdat),
        .i_mem_ack (mem_ack)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic line_t rand_bits(input int n);
        line_t v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[LINE_W-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic addr_t line_base(input addr_t a);
        return {a[31:5], 5'b0};
    endfunction

    // contents of a line that was never written
    function automatic line_t fill_pattern(input addr_t a);
        line_t v;
        for (int k = 0; k < 8; k++)
        begin
            v[k*32 +: 32] = (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ (32'h0101_0101 * k);
        end
        return v;
    endfunction

    function automatic line_t expected_line(input addr_t a);
        if (shadow.exists(line_base(a)))
            return shadow[line_base(a)];
        return fill_pattern(line_base(a));
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input line_t exp, input line_t act);
        if (exp !== act)
        begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // hold the strobe through the ack cycle and return one cycle later
    task automatic wait_ack(input bit data_side);
        int n;
        n = 0;
        do
        begin
            @(posedge clk);
            #1;
            n++;
            if (n > ACK_LIMIT)
                report_failure($sformatf("%s ack never arrived within %0d cycles",
                    data_side ? "data cache" : "instruction cache", ACK_LIMIT));
        end
        while (data_side ? !dc_ack : !ic_ack);
        @(posedge clk);
        #1;
    endtask

    task automatic ifetch_read(input addr_t a);
        ic_expect.push_back(expected_line(a));
        ic_names.push_back($sformatf("ifetch read %h", a));
        ic_cyc = 1'b1;
        ic_stb = 1'b1;
        ic_adr = a;
        wait_ack(1'b0);
        ic_cyc = 1'b0;
        ic_stb = 1'b0;
    endtask

    task automatic data_access(input logic we, input addr_t a, input line_t wd);
        if (we)
        begin
            shadow[line_base(a)] = wd;
            dc_expect.push_back('0);
            dc_names.push_back($sformatf("data write-back ack %h", a));
        end
        else
        begin
            dc_expect.push_back(expected_line(a));
            dc_names.push_back($sformatf("data read %h", a));
        end
        dc_cyc  = 1'b1;
        dc_stb  = 1'b1;
        dc_we   = we;
        dc_adr  = a;
        dc_wdat = wd;
        wait_ack(1'b1);
        dc_cyc = 1'b0;
        dc_stb = 1'b0;
        dc_we  = 1'b0;
    endtask

    // memory model with 0 to 7 wait cycles per access
    initial
    begin
        int wait_left;
        bit busy;
        mem_ack   = 1'b0;
        mem_rdat  = '0;
        busy      = 1'b0;
        wait_left = 0;
        forever
        begin
            @(posedge clk);
            #1;
            mem_ack = 1'b0;
            if (mem_cyc && mem_stb)
            begin
                if (!busy)
                begin
                    busy      = 1'b1;
                    wait_left = int'(rand_bits(3));
                end
                if (wait_left == 0)
                begin
                    mem_log.push_back(mem_adr);
                    if (mem_we)
                        mem_model[mem_adr] = mem_wdat;
                    else if (mem_model.exists(mem_adr))
                        mem_rdat = mem_model[mem_adr];
                    else
                        mem_rdat = fill_pattern(mem_adr);
                    mem_ack = 1'b1;
                    busy    = 1'b0;
                end
                else
                    wait_left--;
            end
        end
    end

    // every cache-side ack is compared against the oldest outstanding request
    always @(posedge clk)
    begin
        #1;
        if (ic_ack)
        begin
            if (ic_expect.size() == 0)
                report_failure("instruction cache ack came with no request outstanding");
            else
                check_value(ic_names.pop_front(), ic_expect.pop_front(), ic_dat);
        end
        if (dc_ack)
        begin
            if (dc_expect.size() == 0)
                report_failure("data cache ack came with no request outstanding");
            else
                check_value(dc_names.pop_front(), dc_expect.pop_front(), dc_rdat);
        end
    end

    initial
    begin
        line_t      wd;
        addr_t      a_i;
        addr_t      a_d;
        logic       last_data;
        logic [1:0] lone;

        rst     = 1'b1;
        ic_cyc  = 1'b0;
        ic_stb  = 1'b0;
        ic_adr  = '0;
        dc_cyc  = 1'b0;
        dc_stb  = 1'b0;
        dc_we   = 1'b0;
        dc_adr  = '0;
        dc_wdat = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("reset state", '0, line_t'({ic_ack, dc_ack, mem_cyc, mem_stb, mem_we,
            UUT.ireq_if.pending, UUT.dreq_if.pending, UUT.ireq_if.done, UUT.dreq_if.done}));

        // first tie after reset goes to data
        mem_log.delete();
        fork
            ifetch_read(32'h0000_1234);
            data_access(1'b0, 32'h0000_8040, '0);
        join
        check_value("tie grant count", line_t'(2), line_t'(mem_log.size()));
        check_value("tie first grant", line_t'(32'h0000_8040), line_t'(mem_log[0]));
        check_value("tie second grant", line_t'(32'h0000_1220), line_t'(mem_log[1]));

        // a tie leaves the same port last, so only lone requests flip the order
        last_data = 1'b0;
        for (int p = 0; p < PAIR_COUNT; p++)
        begin
            a_i  = 32'h0003_0000 + 32'(p * LINE_BYTES);
            a_d  = 32'h0004_0000 + 32'(p * LINE_BYTES);
            // lone kinds step through 0, 3, 2, 1 so each tie order comes up
            lone = 2'((p * 3) % 4);
            if (lone == 2'd1)
            begin
                data_access(1'b0, a_d + 32'h0000_1000, '0);
                last_data = 1'b1;
            end
            else if (lone == 2'd2)
            begin
                ifetch_read(a_i + 32'h0000_1000);
                last_data = 1'b0;
            end
            mem_log.delete();
            fork
                ifetch_read(a_i);
                data_access(1'b0, a_d, '0);
            join
            check_value("pair grant count", line_t'(2), line_t'(mem_log.size()));
            check_value("pair first grant", line_t'(last_data ? a_i : a_d), line_t'(mem_log[0]));
            check_value("pair second grant", line_t'(last_data ? a_d : a_i), line_t'(mem_log[1]));
        end

        // single refill with the offset bits ignored
        ifetch_read(32'h0000_2A1F);

        // write-back then read of the same line
        wd = rand_bits(LINE_W);
        data_access(1'b1, 32'h0000_5007, wd);
        data_access(1'b0, 32'h0000_501C, '0);

        for (int k = 0; k < STREAM_LEN; k++)
        begin
            ic_addrs[k] = 32'h0001_0000 + 32'(rand_bits(9));
            dc_addrs[k] = 32'h0002_0000 + 32'(rand_bits(8));
            dc_wes[k]   = rand_bits(1) != '0;
            dc_wdats[k] = rand_bits(LINE_W);
        end
        fork
            begin
                for (int k = 0; k < STREAM_LEN; k++)
                    ifetch_read(ic_addrs[k]);
            end
            begin
                for (int k = 0; k < STREAM_LEN; k++)
                    data_access(dc_wes[k], dc_addrs[k], dc_wdats[k]);
            end
        join

        if (ic_expect.size() != 0 || dc_expect.size() != 0)
            report_failure("some requests finished without a checked ack");
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
source/refill_pkg.sv
source/line_req_if.sv
source/ifetch_refill_port.sv
source/data_refill_port.sv
source/refill_arbiter.sv
source/refill_top.sv
tests/refill_top_props.sv
tests/tb_refill_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_refill_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TEST PASS

SOURCES := $(filter-out +%,$(shell cat files.f))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) files.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f files.f

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
